//--- logic/dma_ram_defines.svh
`ifndef DMA_RAM_DEFINES_SVH
`define DMA_RAM_DEFINES_SVH

// Byte address width on the cache DMA side
`define DMA_ADDR_WIDTH 32

// One data beat, same width on the DMA port and on the AXI side
`define DATA_WIDTH 64

// Beats per cache block, also the AXI burst length
`define BURST_BEATS 4

// Memory byte address width
// Upper DMA address bits are dropped here, so addresses wrap
`define AXI_ADDR_WIDTH 28

// RAM model depth in beats
`define MEM_WORDS 1024

// Cycles from the end of reset until the memory reports calibration done
`define CALIB_CYCLES 64

`endif

//--- logic/dma_ram_pkg.sv
`include "dma_ram_defines.svh"

package dma_ram_pkg;

    // Block request from the cache DMA port
    // One packet moves BURST_BEATS beats in either direction
    typedef struct packed {
        logic                       write_not_read;
        logic [`DMA_ADDR_WIDTH-1:0] addr;
    } dma_pkt_s;

    // Burst address on the AW and AR channels
    // Length, size and burst type are fixed, so only the address travels
    typedef struct packed {
        logic [`AXI_ADDR_WIDTH-1:0] addr;
    } axi_addr_s;

    // One beat on the W or R channel
    typedef struct packed {
        logic [`DATA_WIDTH-1:0] data;
        logic                   last;
    } axi_beat_s;

endpackage

//--- logic/axi_ram.sv
`timescale 1ns/1ps
`include "dma_ram_defines.svh"

module axi_ram
    import dma_ram_pkg::*;
    (input  logic      ui_clk_lo
    ,input  logic      rst_i

    ,input  axi_addr_s aw_i
    ,input  logic      aw_v_i
    ,output logic      aw_ready_o
    ,input  axi_beat_s w_i
    ,input  logic      w_v_i
    ,output logic      w_ready_o
    ,output logic      b_v_o
    ,input  logic      b_ready_i

    ,input  axi_addr_s ar_i
    ,input  logic      ar_v_i
    ,output logic      ar_ready_o
    ,output axi_beat_s r_o
    ,output logic      r_v_o
    ,input  logic      r_ready_i

    ,output logic      calib_done_o
    );

    localparam int BYTE_OFS = $clog2(`DATA_WIDTH / 8);
    localparam int WORD_W   = $clog2(`MEM_WORDS);
    localparam int BEAT_W   = $clog2(`BURST_BEATS);
    localparam int CALIB_W  = $clog2(`CALIB_CYCLES + 1);

    typedef enum logic [1:0] {
        W_IDLE,
        W_DATA,
        W_RESP
    } wr_state_e;

    typedef enum logic {
        R_IDLE,
        R_BURST
    } rd_state_e;

    logic [`DATA_WIDTH-1:0] mem [`MEM_WORDS];

    wr_state_e         wr_state;
    logic [WORD_W-1:0] wr_ptr;
    rd_state_e         rd_state;
    logic [WORD_W-1:0] rd_ptr;
    logic [BEAT_W-1:0] rd_cnt;

    logic [CALIB_W-1:0] calib_cnt;
    logic               calib_done;

    // Count up after reset, then report calibration done for good
    always_ff @(posedge ui_clk_lo) begin
        if (rst_i) begin
            calib_cnt  <= '0;
            calib_done <= 1'b0;
        end else begin
            if (calib_cnt != CALIB_W'(`CALIB_CYCLES))
                calib_cnt <= calib_cnt + 1'b1;
            else
                calib_done <= 1'b1;
        end
    end

    assign calib_done_o = calib_done;

    // Write side
    assign aw_ready_o = calib_done & (wr_state == W_IDLE);
    assign w_ready_o  = (wr_state == W_DATA);
    assign b_v_o      = (wr_state == W_RESP);

    always_ff @(posedge ui_clk_lo) begin
        if (rst_i) begin
            wr_state <= W_IDLE;
            wr_ptr   <= '0;
        end else begin
            case (wr_state)
                W_IDLE: begin
                    if (aw_v_i && aw_ready_o) begin
                        // Word index wraps at MEM_WORDS
                        wr_ptr   <= aw_i.addr[BYTE_OFS +: WORD_W];
                        wr_state <= W_DATA;
                    end
                end
                W_DATA: begin
                    if (w_v_i) begin
                        wr_ptr <= wr_ptr + 1'b1;
                        if (w_i.last)
                            wr_state <= W_RESP;
                    end
                end
                default: begin
                    if (b_ready_i)
                        wr_state <= W_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge ui_clk_lo) begin
        if (w_v_i && w_ready_o)
            mem[wr_ptr] <= w_i.data;
    end

    // Read side, first beat one cycle after AR
    assign ar_ready_o = calib_done & (rd_state == R_IDLE);
    assign r_v_o      = (rd_state == R_BURST);
    assign r_o.data   = mem[rd_ptr];
    assign r_o.last   = (rd_cnt == BEAT_W'(`BURST_BEATS - 1));

    always_ff @(posedge ui_clk_lo) begin
        if (rst_i) begin
            rd_state <= R_IDLE;
            rd_ptr   <= '0;
            rd_cnt   <= '0;
        end else begin
            case (rd_state)
                R_IDLE: begin
                    if (ar_v_i && ar_ready_o) begin
                        rd_ptr   <= ar_i.addr[BYTE_OFS +: WORD_W];
                        rd_cnt   <= '0;
                        rd_state <= R_BURST;
                    end
                end
                default: begin
                    if (r_ready_i) begin
                        rd_ptr <= rd_ptr + 1'b1;
                        rd_cnt <= rd_cnt + 1'b1;
                        if (r_o.last)
                            rd_state <= R_IDLE;
                    end
                end
            endcase
        end
    end

    // A stalled beat must not change under the reader
    a_r_stable: assert property (@(posedge ui_clk_lo) disable iff (rst_i)
        (r_v_o && !r_ready_i) |=> (r_v_o && $stable(r_o)));

endmodule

//--- logic/dma_axi_writer.sv
`timescale 1ns/1ps
`include "dma_ram_defines.svh"

module dma_axi_writer
    import dma_ram_pkg::*;
    (input  logic                   ui_clk_lo
    ,input  logic                   rst_i

    ,input  logic                   start_i
    ,input  axi_addr_s              addr_i
    ,output logic                   busy_o

    ,input  logic [`DATA_WIDTH-1:0] dma_data_i
    ,input  logic                   dma_data_v_i
    ,output logic                   dma_data_yumi_o

    ,output axi_addr_s              aw_o
    ,output logic                   aw_v_o
    ,input  logic                   aw_ready_i
    ,output axi_beat_s              w_o
    ,output logic                   w_v_o
    ,input  logic                   w_ready_i
    ,input  logic                   b_v_i
    ,output logic                   b_ready_o
    );

    localparam int BEAT_W = $clog2(`BURST_BEATS);

    typedef enum logic [1:0] {
        S_IDLE,
        S_ADDR,
        S_DATA,
        S_RESP
    } wr_state_e;

    wr_state_e         state;
    axi_addr_s         addr_r;
    logic [BEAT_W-1:0] beat_cnt;
    logic              beat_xfer;
    logic              last_beat;

    assign last_beat = (beat_cnt == BEAT_W'(`BURST_BEATS - 1));
    assign beat_xfer = w_v_o & w_ready_i;

    assign busy_o = (state != S_IDLE);

    assign aw_o   = addr_r;
    assign aw_v_o = (state == S_ADDR);

    // Write data goes straight from the DMA port onto W
    assign w_v_o           = (state == S_DATA) & dma_data_v_i;
    assign w_o.data        = dma_data_i;
    assign w_o.last        = last_beat;
    assign dma_data_yumi_o = beat_xfer;

    assign b_ready_o = (state == S_RESP);

    always_ff @(posedge ui_clk_lo) begin
        if (rst_i) begin
            state    <= S_IDLE;
            beat_cnt <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    beat_cnt <= '0;
                    if (start_i)
                        state <= S_ADDR;
                end
                S_ADDR: begin
                    if (aw_ready_i)
                        state <= S_DATA;
                end
                S_DATA: begin
                    if (beat_xfer) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (last_beat)
                            state <= S_RESP;
                    end
                end
                default: begin
                    // Response is always OKAY
                    if (b_v_i)
                        state <= S_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge ui_clk_lo) begin
        if (start_i && state == S_IDLE)
            addr_r <= addr_i;
    end

    // After the final beat W goes quiet and the memory answers at once
    a_last_then_resp: assert property (@(posedge ui_clk_lo) disable iff (rst_i)
        (beat_xfer && w_o.last) |=> (b_ready_o && b_v_i && !w_v_o));

endmodule

//--- logic/dma_axi_reader.sv
`timescale 1ns/1ps
`include "dma_ram_defines.svh"

module dma_axi_reader
    import dma_ram_pkg::*;
    (input  logic                   ui_clk_lo
    ,input  logic                   rst_i

    ,input  logic                   start_i
    ,input  axi_addr_s              addr_i
    ,output logic                   busy_o

    ,output logic [`DATA_WIDTH-1:0] dma_data_o
    ,output logic                   dma_data_v_o
    ,input  logic                   dma_data_ready_i

    ,output axi_addr_s              ar_o
    ,output logic                   ar_v_o
    ,input  logic                   ar_ready_i
    ,input  axi_beat_s              r_i
    ,input  logic                   r_v_i
    ,output logic                   r_ready_o
    );

    typedef enum logic [1:0] {
        S_IDLE,
        S_ADDR,
        S_DATA
    } rd_state_e;

    rd_state_e state;
    axi_addr_s addr_r;

    assign busy_o = (state != S_IDLE);

    assign ar_o   = addr_r;
    assign ar_v_o = (state == S_ADDR);

    // R flows through untouched, DMA back-pressure becomes R ready
    assign dma_data_o   = r_i.data;
    assign dma_data_v_o = (state == S_DATA) & r_v_i;
    assign r_ready_o    = (state == S_DATA) & dma_data_ready_i;

    always_ff @(posedge ui_clk_lo) begin
        if (rst_i) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE: begin
                    if (start_i)
                        state <= S_ADDR;
                end
                S_ADDR: begin
                    if (ar_ready_i)
                        state <= S_DATA;
                end
                default: begin
                    // Burst ends on the beat the memory marks last
                    if (r_v_i && r_ready_o && r_i.last)
                        state <= S_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge ui_clk_lo) begin
        if (start_i && state == S_IDLE)
            addr_r <= addr_i;
    end

endmodule

//--- logic/dma_axi_bridge.sv
`timescale 1ns/1ps
`include "dma_ram_defines.svh"

module dma_axi_bridge
    import dma_ram_pkg::*;
    (input  logic                   ui_clk_lo
    ,input  logic                   rst_i

    ,input  dma_pkt_s               dma_pkt_i
    ,input  logic                   dma_pkt_v_i
    ,output logic                   dma_pkt_yumi_o

    ,output logic [`DATA_WIDTH-1:0] dma_data_o
    ,output logic                   dma_data_v_o
    ,input  logic                   dma_data_ready_i

    ,input  logic [`DATA_WIDTH-1:0] dma_data_i
    ,input  logic                   dma_data_v_i
    ,output logic                   dma_data_yumi_o

    ,input  logic                   calib_done_i

    ,output axi_addr_s              aw_o
    ,output logic                   aw_v_o
    ,input  logic                   aw_ready_i
    ,output axi_beat_s              w_o
    ,output logic                   w_v_o
    ,input  logic                   w_ready_i
    ,input  logic                   b_v_i
    ,output logic                   b_ready_o

    ,output axi_addr_s              ar_o
    ,output logic                   ar_v_o
    ,input  logic                   ar_ready_i
    ,input  axi_beat_s              r_i
    ,input  logic                   r_v_i
    ,output logic                   r_ready_o
    );

    logic      wr_busy, rd_busy;
    logic      pkt_accept;
    axi_addr_s pkt_addr;

    // One transaction at a time and nothing until the memory is calibrated
    assign pkt_accept     = dma_pkt_v_i & calib_done_i & ~wr_busy & ~rd_busy;
    assign dma_pkt_yumi_o = pkt_accept;

    // Drop the upper address bits so the memory space wraps
    assign pkt_addr.addr = dma_pkt_i.addr[`AXI_ADDR_WIDTH-1:0];

    dma_axi_writer writer
        (.ui_clk_lo      (ui_clk_lo)
        ,.rst_i          (rst_i)
        ,.start_i        (pkt_accept & dma_pkt_i.write_not_read)
        ,.addr_i         (pkt_addr)
        ,.busy_o         (wr_busy)
        ,.dma_data_i     (dma_data_i)
        ,.dma_data_v_i   (dma_data_v_i)
        ,.dma_data_yumi_o(dma_data_yumi_o)
        ,.aw_o           (aw_o)
        ,.aw_v_o         (aw_v_o)
        ,.aw_ready_i     (aw_ready_i)
        ,.w_o            (w_o)
        ,.w_v_o          (w_v_o)
        ,.w_ready_i      (w_ready_i)
        ,.b_v_i          (b_v_i)
        ,.b_ready_o      (b_ready_o)
        );

    dma_axi_reader reader
        (.ui_clk_lo       (ui_clk_lo)
        ,.rst_i           (rst_i)
        ,.start_i         (pkt_accept & ~dma_pkt_i.write_not_read)
        ,.addr_i          (pkt_addr)
        ,.busy_o          (rd_busy)
        ,.dma_data_o      (dma_data_o)
        ,.dma_data_v_o    (dma_data_v_o)
        ,.dma_data_ready_i(dma_data_ready_i)
        ,.ar_o            (ar_o)
        ,.ar_v_o          (ar_v_o)
        ,.ar_ready_i      (ar_ready_i)
        ,.r_i             (r_i)
        ,.r_v_i           (r_v_i)
        ,.r_ready_o       (r_ready_o)
        );

    // Calibration never drops once reported, so yumi never precedes it
    a_calib_sticky: assert property (@(posedge ui_clk_lo) disable iff (rst_i)
        calib_done_i |=> calib_done_i);

endmodule

//--- logic/dma_ram_top.sv
`timescale 1ns/1ps
`include "dma_ram_defines.svh"

module dma_ram_top
    import dma_ram_pkg::*;
    (input  logic                   ui_clk_lo
    ,input  logic                   rst_i

    ,input  dma_pkt_s               dma_pkt_i
    ,input  logic                   dma_pkt_v_i
    ,output logic                   dma_pkt_yumi_o

    ,output logic [`DATA_WIDTH-1:0] dma_data_o
    ,output logic                   dma_data_v_o
    ,input  logic                   dma_data_ready_i

    ,input  logic [`DATA_WIDTH-1:0] dma_data_i
    ,input  logic                   dma_data_v_i
    ,output logic                   dma_data_yumi_o

    ,output logic                   init_calib_complete_o
    );

    // Write address, data and response
    axi_addr_s aw;
    logic      aw_v, aw_ready;
    axi_beat_s w;
    logic      w_v, w_ready;
    logic      b_v, b_ready;

    // Read address and data
    axi_addr_s ar;
    logic      ar_v, ar_ready;
    axi_beat_s r;
    logic      r_v, r_ready;

    dma_axi_bridge bridge
        (.ui_clk_lo       (ui_clk_lo)
        ,.rst_i           (rst_i)
        ,.dma_pkt_i       (dma_pkt_i)
        ,.dma_pkt_v_i     (dma_pkt_v_i)
        ,.dma_pkt_yumi_o  (dma_pkt_yumi_o)
        ,.dma_data_o      (dma_data_o)
        ,.dma_data_v_o    (dma_data_v_o)
        ,.dma_data_ready_i(dma_data_ready_i)
        ,.dma_data_i      (dma_data_i)
        ,.dma_data_v_i    (dma_data_v_i)
        ,.dma_data_yumi_o (dma_data_yumi_o)
        ,.calib_done_i    (init_calib_complete_o)
        ,.aw_o            (aw)
        ,.aw_v_o          (aw_v)
        ,.aw_ready_i      (aw_ready)
        ,.w_o             (w)
        ,.w_v_o           (w_v)
        ,.w_ready_i       (w_ready)
        ,.b_v_i           (b_v)
        ,.b_ready_o       (b_ready)
        ,.ar_o            (ar)
        ,.ar_v_o          (ar_v)
        ,.ar_ready_i      (ar_ready)
        ,.r_i             (r)
        ,.r_v_i           (r_v)
        ,.r_ready_o       (r_ready)
        );

    axi_ram ram
        (.ui_clk_lo   (ui_clk_lo)
        ,.rst_i       (rst_i)
        ,.aw_i        (aw)
        ,.aw_v_i      (aw_v)
        ,.aw_ready_o  (aw_ready)
        ,.w_i         (w)
        ,.w_v_i       (w_v)
        ,.w_ready_o   (w_ready)
        ,.b_v_o       (b_v)
        ,.b_ready_i   (b_ready)
        ,.ar_i        (ar)
        ,.ar_v_i      (ar_v)
        ,.ar_ready_o  (ar_ready)
        ,.r_o         (r)
        ,.r_v_o       (r_v)
        ,.r_ready_i   (r_ready)
        ,.calib_done_o(init_calib_complete_o)
        );

endmodule

//--- bench/dma_ram_tb_tasks.svh
// Every test task starts and ends at a drive point 2 ns after a rising edge

task automatic abort_run(input string what);
    $display("%s at time %0t", what, $time);
    $display("STATUS: FAIL");
    $fatal(1, "run aborted");
endtask

task automatic check_value(input string name, input logic [63:0] actual,
                           input logic [63:0] expected);
    if (actual !== expected) begin
        $display("ERROR: time %0t signal %s actual 0x%h expected 0x%h",
                 $time, name, actual, expected);
        $display("STATUS: FAIL");
        $fatal(1, "value mismatch");
    end
endtask

task automatic next_drive();
    @(posedge ui_clk_lo);
    #(DRIVE_DELAY);
endtask

// RAM word of a beat with upper address bits dropped and the word index wrapped
function automatic int word_index(input logic [31:0] addr, input int unsigned beat);
    int unsigned byte_addr;
    byte_addr = addr & ((32'd1 << `AXI_ADDR_WIDTH) - 32'd1);
    return (byte_addr / (`DATA_WIDTH / 8) + beat) % `MEM_WORDS;
endfunction

// Spacing of 140 words keeps the eight blocks apart
function automatic logic [31:0] spread_addr(input int k);
    return 32'h0001_0000 + 32'(k) * 32'h0000_0460;
endfunction

task automatic random_block(output block_t blk);
    for (int i = 0; i < `BURST_BEATS; i++)
        blk[i] = {$random(seed), $random(seed)};
endtask

task automatic reference_block(input logic [31:0] addr, output block_t blk);
    for (int i = 0; i < `BURST_BEATS; i++)
        blk[i] = ref_mem[word_index(addr, i)];
endtask

task automatic wait_pkt_yumi();
    int waited;
    waited = 0;
    @(negedge ui_clk_lo);
    while (!dma_pkt_yumi_o) begin
        waited++;
        if (waited > HANDSHAKE_LIMIT)
            abort_run("Packet was never accepted");
        next_drive();
        @(negedge ui_clk_lo);
    end
endtask

task automatic wait_data_yumi();
    int waited;
    waited = 0;
    @(negedge ui_clk_lo);
    while (!dma_data_yumi_o) begin
        waited++;
        if (waited > HANDSHAKE_LIMIT)
            abort_run("Write beat was never consumed");
        next_drive();
        @(negedge ui_clk_lo);
    end
endtask

task automatic send_packet(input logic write_not_read, input logic [31:0] addr);
    dma_pkt_i.write_not_read = write_not_read;
    dma_pkt_i.addr           = addr;
    dma_pkt_v_i              = 1'b1;
    wait_pkt_yumi();
    next_drive();
    dma_pkt_v_i = 1'b0;
endtask

// Optional gaps of up to three idle cycles before each beat
task automatic write_block(input logic [31:0] addr, input block_t blk, input bit gaps);
    logic [31:0] r;
    int          gap;
    send_packet(1'b1, addr);
    for (int i = 0; i < `BURST_BEATS; i++) begin
        r            = $random(seed);
        gap          = gaps ? int'(r[1:0]) : 0;
        dma_data_v_i = 1'b0;
        repeat (gap) next_drive();
        dma_data_i   = blk[i];
        dma_data_v_i = 1'b1;
        wait_data_yumi();
        next_drive();
        ref_mem[word_index(addr, i)] = blk[i];
    end
    dma_data_v_i = 1'b0;
endtask

// A stalled beat must already show the next expected word
task automatic read_block(input logic [31:0] addr, input block_t blk, input bit stall);
    logic [31:0] r;
    int          got;
    int          waited;
    send_packet(1'b0, addr);
    got    = 0;
    waited = 0;
    while (got < `BURST_BEATS) begin
        r                = $random(seed);
        dma_data_ready_i = stall ? r[0] : 1'b1;
        @(negedge ui_clk_lo);
        if (dma_data_v_o) begin
            check_value("dma_data_o", dma_data_o, blk[got]);
            if (dma_data_ready_i)
                got++;
        end
        waited++;
        if (waited > HANDSHAKE_LIMIT)
            abort_run("Read burst did not deliver four beats");
        next_drive();
    end
    dma_data_ready_i = 1'b0;
    @(negedge ui_clk_lo);
    check_value("dma_data_v_o", 64'(dma_data_v_o), 64'd0);
    next_drive();
endtask

// A held packet sees no yumi until calibration completes
task automatic calibration_test();
    dma_pkt_i.write_not_read = 1'b1;
    dma_pkt_i.addr           = 32'h0000_0040;
    dma_pkt_v_i              = 1'b1;
    @(negedge ui_clk_lo);
    check_value("init_calib_complete_o", 64'(init_calib_complete_o), 64'd0);
    check_value("dma_data_v_o", 64'(dma_data_v_o), 64'd0);
    check_value("dma_data_yumi_o", 64'(dma_data_yumi_o), 64'd0);
    for (int cycle = 1; cycle <= `CALIB_CYCLES; cycle++) begin
        next_drive();
        @(negedge ui_clk_lo);
        check_value("init_calib_complete_o", 64'(init_calib_complete_o), 64'd0);
        check_value("dma_pkt_yumi_o", 64'(dma_pkt_yumi_o), 64'd0);
    end
    next_drive();
    dma_pkt_v_i = 1'b0;
    @(negedge ui_clk_lo);
    check_value("init_calib_complete_o", 64'(init_calib_complete_o), 64'd1);
    next_drive();
endtask

task automatic write_read_test();
    block_t blk;
    blk[0] = 64'h0123_4567_89ab_cdef;
    blk[1] = 64'hfedc_ba98_7654_3210;
    blk[2] = 64'hdead_beef_0000_0001;
    blk[3] = 64'h5555_aaaa_3333_cccc;
    write_block(32'h0000_0100, blk, 1'b0);
    read_block(32'h0000_0100, blk, 1'b0);
endtask

task automatic multi_block_test();
    block_t blk;
    for (int k = 0; k < 8; k++) begin
        random_block(blk);
        write_block(spread_addr(k), blk, 1'b0);
    end
    // Read order 0 5 2 7 4 1 6 3
    for (int k = 0; k < 8; k++) begin
        reference_block(spread_addr((k * 5) % 8), blk);
        read_block(spread_addr((k * 5) % 8), blk, 1'b0);
    end
endtask

task automatic backpressure_test();
    block_t blk;
    for (int k = 0; k < 8; k++) begin
        reference_block(spread_addr(k), blk);
        read_block(spread_addr(k), blk, 1'b1);
    end
    for (int k = 0; k < 4; k++) begin
        random_block(blk);
        write_block(32'h0000_0a00 + 32'(k) * 32'h100, blk, 1'b1);
    end
    for (int k = 0; k < 4; k++) begin
        reference_block(32'h0000_0a00 + 32'(k) * 32'h100, blk);
        read_block(32'h0000_0a00 + 32'(k) * 32'h100, blk, 1'b1);
    end
endtask

task automatic wrap_test();
    block_t      blk;
    logic [31:0] a;
    // Word 1022 makes the burst itself wrap to word 0
    a = 32'h0000_1ff0;
    random_block(blk);
    write_block(a, blk, 1'b0);
    read_block(a + 32'(`MEM_WORDS * (`DATA_WIDTH / 8)), blk, 1'b0);
    read_block(a + (32'd1 << `AXI_ADDR_WIDTH), blk, 1'b1);
endtask

//--- bench/dma_ram_tb.sv
`timescale 1ns/1ps
`include "dma_ram_defines.svh"

module dma_ram_tb
    import dma_ram_pkg::*;
    ();

    localparam int CLK_PERIOD      = 40;
    localparam int DRIVE_DELAY     = 2;
    localparam int RESET_CYCLES    = 5;
    localparam int NUM_TESTS       = 5;
    localparam int HANDSHAKE_LIMIT = 200;

    typedef logic [`DATA_WIDTH-1:0] block_t [`BURST_BEATS];

    logic                   ui_clk_lo;
    logic                   rst_i;
    dma_pkt_s               dma_pkt_i;
    logic                   dma_pkt_v_i;
    logic                   dma_pkt_yumi_o;
    logic [`DATA_WIDTH-1:0] dma_data_o;
    logic                   dma_data_v_o;
    logic                   dma_data_ready_i;
    logic [`DATA_WIDTH-1:0] dma_data_i;
    logic                   dma_data_v_i;
    logic                   dma_data_yumi_o;
    logic                   init_calib_complete_o;

    // Expected memory contents, indexed by word like the RAM
    logic [`DATA_WIDTH-1:0] ref_mem [`MEM_WORDS];
    integer                 seed;

    `include "dma_ram_tb_tasks.svh"

    dma_ram_top uut
        (.ui_clk_lo            (ui_clk_lo)
        ,.rst_i                (rst_i)
        ,.dma_pkt_i            (dma_pkt_i)
        ,.dma_pkt_v_i          (dma_pkt_v_i)
        ,.dma_pkt_yumi_o       (dma_pkt_yumi_o)
        ,.dma_data_o           (dma_data_o)
        ,.dma_data_v_o         (dma_data_v_o)
        ,.dma_data_ready_i     (dma_data_ready_i)
        ,.dma_data_i           (dma_data_i)
        ,.dma_data_v_i         (dma_data_v_i)
        ,.dma_data_yumi_o      (dma_data_yumi_o)
        ,.init_calib_complete_o(init_calib_complete_o)
        );

    always #(CLK_PERIOD / 2) ui_clk_lo = ~ui_clk_lo;

    // Generous bound, each test takes far less than 2000 cycles
    initial begin
        #(NUM_TESTS * 2000 * CLK_PERIOD);
        abort_run("Watchdog expired before all tests finished");
    end

    initial begin
        ui_clk_lo        = 1'b0;
        rst_i            = 1'b1;
        dma_pkt_i        = '0;
        dma_pkt_v_i      = 1'b0;
        dma_data_ready_i = 1'b0;
        dma_data_i       = '0;
        dma_data_v_i     = 1'b0;
        seed             = 4494;

        repeat (RESET_CYCLES) @(posedge ui_clk_lo);
        #(DRIVE_DELAY);
        rst_i = 1'b0;

        calibration_test();
        write_read_test();
        multi_block_test();
        backpressure_test();
        wrap_test();

        $display("STATUS: PASS");
        $finish;
    end

endmodule

//--- dma_ram_top.f
+incdir+logic
+incdir+bench
logic/dma_ram_pkg.sv
logic/axi_ram.sv
logic/dma_axi_writer.sv
logic/dma_axi_reader.sv
logic/dma_axi_bridge.sv
logic/dma_ram_top.sv
bench/dma_ram_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the DMA to RAM bridge testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module dma_ram_tb \
    -f dma_ram_top.f \
    -o dma_ram_sim

./obj_dir/dma_ram_sim
